//--- bench/cpu_golden.txt
# test run rwcs ldua ldla lcs wpt rpt wsel idb_in stoc_n sel mask, then expected values
# idb_out cd_out lua topcsb ppn pil trap halted test_out; mask bit 0 idb_out .. bit 8 test_out
1 0 0 1 0 0 0 0 0 0030 1 0 1f7 0000 0000 00 0000000000000000 0000 0 0 0 00
1 0 0 0 0 1 0 0 0 0121 1 0 1f7 0000 0000 30 0000000000000000 0000 0 0 0 10
1 0 0 0 0 1 0 0 1 0062 1 0 1f7 0000 0000 30 0000000000000000 0000 0 0 0 10
1 0 0 0 0 1 0 0 2 5A5A 1 0 1f7 0000 0000 30 0000000000000000 0000 0 0 0 10
1 0 0 0 0 1 0 0 3 A5A5 1 0 1f7 0000 0000 30 0000000000000000 0000 0 0 0 10
1 0 1 0 0 0 0 0 0 0000 1 0 1ff 0121 0000 30 A5A55A5A00620121 0000 0 0 0 10
1 0 1 0 0 0 0 0 1 0000 1 0 1ff 0062 0000 30 A5A55A5A00620121 0000 0 0 0 10
1 0 1 0 0 0 0 0 2 0000 1 0 1ff 5A5A 0000 30 A5A55A5A00620121 0000 0 0 0 10
1 0 1 0 0 0 0 0 3 0000 1 0 1ff A5A5 0000 30 A5A55A5A00620121 0000 0 0 0 10
2 0 0 0 1 0 0 0 0 0800 1 0 1ff 0000 0000 30 A5A55A5A00620121 0000 0 0 0 10
2 0 0 0 0 0 1 0 0 9234 1 0 1ff 0000 0000 30 A5A55A5A00620121 0000 0 0 0 10
2 0 0 0 0 0 0 1 0 0000 1 0 1ff 9234 0000 30 A5A55A5A00620121 0000 0 0 0 10
2 0 0 0 1 0 0 0 0 1400 1 0 1ff 0000 0000 30 A5A55A5A00620121 0000 0 0 0 10
2 0 0 0 0 0 0 1 0 0000 1 0 1ff 0000 0000 30 A5A55A5A00620121 0000 0 0 0 10
3 0 0 1 0 0 0 0 0 0010 1 0 000 0000 0000 00 0000000000000000 0000 0 0 0 00
3 0 0 0 0 1 0 0 0 0070 1 0 000 0000 0000 00 0000000000000000 0000 0 0 0 00
3 0 0 0 0 1 0 0 1 0022 1 0 000 0000 0000 00 0000000000000000 0000 0 0 0 00
3 0 0 0 0 1 0 0 2 0010 1 0 000 0000 0000 00 0000000000000000 0000 0 0 0 00
3 0 0 0 0 1 0 0 3 0000 1 0 000 0000 0000 00 0000000000000000 0000 0 0 0 00
3 0 0 1 0 0 0 0 0 0011 1 0 000 0000 0000 00 0000000000000000 0000 0 0 0 00
3 0 0 0 0 1 0 0 0 00BC 1 0 000 0000 0000 00 0000000000000000 0000 0 0 0 00
3 0 0 0 0 1 0 0 1 0024 1 0 000 0000 0000 00 0000000000000000 0000 0 0 0 00
3 0 0 0 0 1 0 0 2 0018 1 0 000 0000 0000 00 0000000000000000 0000 0 0 0 00
3 0 0 0 0 1 0 0 3 0000 1 0 000 0000 0000 00 0000000000000000 0000 0 0 0 00
3 0 0 1 0 0 0 0 0 0012 1 0 000 0000 0000 00 0000000000000000 0000 0 0 0 00
3 0 0 0 0 1 0 0 0 60C6 1 0 000 0000 0000 00 0000000000000000 0000 0 0 0 00
3 0 0 0 0 1 0 0 1 0026 1 0 000 0000 0000 00 0000000000000000 0000 0 0 0 00
3 0 0 0 0 1 0 0 2 0000 1 0 000 0000 0000 00 0000000000000000 0000 0 0 0 00
3 0 0 0 0 1 0 0 3 0000 1 0 000 0000 0000 00 0000000000000000 0000 0 0 0 00
3 0 0 1 0 0 0 0 0 0010 1 0 000 0000 0000 00 0000000000000000 0000 0 0 0 00
3 1 0 0 0 0 0 0 0 0000 1 0 1ff 0000 0000 10 0000001000220070 0000 0 0 0 10
3 1 0 0 0 0 0 0 0 0000 1 0 1ff 0000 0000 10 0000001000220070 0000 0 0 0 10
4 1 0 0 0 0 0 0 0 0000 1 0 1ff 0800 0000 11 00000018002400BC 1234 3 0 0 11
4 1 0 0 0 0 0 0 0 0000 1 0 1ff 0000 0000 12 00000000002660C6 0000 5 0 0 12
5 1 0 0 0 0 0 0 0 0000 1 0 1ff 0000 0000 30 A5A55A5A00620121 0000 6 1 0 10
5 1 0 0 0 0 0 0 0 0000 1 0 1ff 0000 0000 30 A5A55A5A00620121 0000 9 1 1 10
5 0 0 0 0 0 0 0 0 0000 1 0 1ff 0000 0000 30 A5A55A5A00620121 0000 9 1 1 10
5 0 0 0 0 0 0 0 0 0000 1 0 1ff 0000 0000 30 A5A55A5A00620121 0000 9 1 0 10
6 0 1 0 0 0 0 0 0 00F0 0 0 1ff 0121 01F1 30 A5A55A5A00620121 0000 9 1 0 10
6 0 1 0 0 0 0 0 0 00F0 1 0 1ff 0121 0000 30 A5A55A5A00620121 0000 9 1 0 10
6 0 0 0 0 0 0 0 0 1234 0 0 1ff 0000 1234 30 A5A55A5A00620121 0000 9 1 0 10
7 0 0 1 0 0 0 0 0 00C5 1 0 1ff 0000 0000 30 A5A55A5A00620121 0000 9 1 0 10
7 0 0 0 0 0 0 0 0 0000 1 0 1f7 0000 0000 C5 0000000000000000 0000 9 1 0 05
7 0 0 0 0 0 0 0 0 0000 1 1 1f7 0000 0000 C5 0000000000000000 0000 9 1 0 03
7 0 0 0 0 0 0 0 0 0000 1 2 1f7 0000 0000 C5 0000000000000000 0000 9 1 0 19
7 0 0 0 0 0 0 0 0 0000 1 3 1f7 0000 0000 C5 0000000000000000 0000 9 1 0 01
7 0 0 0 0 0 0 0 0 0000 1 4 1f7 0000 0000 C5 0000000000000000 0000 9 1 0 00
7 0 0 0 0 0 0 0 0 0000 1 5 1f7 0000 0000 C5 0000000000000000 0000 9 1 0 00
7 0 0 0 0 0 0 0 0 0000 1 6 1f7 0000 0000 C5 0000000000000000 0000 9 1 0 00
7 0 0 0 0 0 0 0 0 0000 1 7 1f7 0000 0000 C5 0000000000000000 0000 9 1 0 00

//--- tb.f
hw/cpu_pkg.sv
hw/cpu_proc.sv
hw/cpu_cs.sv
hw/cpu_mmu.sv
hw/cpu_board.sv
bench/cpu_checker.sv
bench/tb_cpu_board.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_cpu_board -f tb.f -o sim_tb_cpu_board

out="$(./obj_dir/sim_tb_cpu_board)"
echo "$out"

if grep -qx "Testbench passed" <<< "$out"; then
  exit 0
fi
exit 1

//--- bench/tb_cpu_board.sv
/* CPU board testbench
   Clock, reset, watchdog, golden record reader and stimulus driver */

`timescale 1ns/1ps

module tb_cpu_board import cpu_pkg::*; ();

  localparam int MAX_REC    = 256;
  localparam int CLK_PERIOD = 20;

  // One record of input stimulus
  typedef struct packed {
    board_ctrl_t      ctl;
    data_word_t       idb_in;
    logic             stoc_n;
    logic [SEL_W-1:0] sel;
  } stim_t;

  logic             sysclk;
  logic             reset;
  board_ctrl_t      ctl;
  data_word_t       idb_in;
  logic             stoc_n;
  logic [SEL_W-1:0] sel_testmux;
  data_word_t       idb_out, cd_out;
  cs_addr_t         lua;
  micro_t           topcsb;
  ppn_t             ppn;
  pil_t             pil;
  logic             trap, halted;
  test_t            test_out;

  // Golden records
  stim_t      stim_mem [MAX_REC];
  int         test_mem [MAX_REC];
  logic [8:0] mask_mem [MAX_REC];
  data_word_t eidb_mem [MAX_REC];
  data_word_t ecd_mem  [MAX_REC];
  cs_addr_t   elua_mem [MAX_REC];
  micro_t     ecsb_mem [MAX_REC];
  ppn_t       eppn_mem [MAX_REC];
  pil_t       epil_mem [MAX_REC];
  logic       etrap_mem [MAX_REC];
  logic       ehalt_mem [MAX_REC];
  test_t      etest_mem [MAX_REC];
  int         nrec;
  logic       loaded = 1'b0;
  logic       load_ok;

  // Expected values handed to the checker
  logic       check_en, flush;
  int         test_id;
  logic [8:0] exp_mask;
  data_word_t exp_idb, exp_cd;
  cs_addr_t   exp_lua;
  micro_t     exp_csb;
  ppn_t       exp_ppn;
  pil_t       exp_pil;
  logic       exp_trap, exp_halted;
  test_t      exp_test;
  int         mismatches, tests_run, tests_failed;

  cpu_board DUT (
    .sysclk(sysclk), .reset(reset), .ctl(ctl), .idb_in(idb_in),
    .stoc_n(stoc_n), .sel_testmux(sel_testmux), .idb_out(idb_out),
    .cd_out(cd_out), .lua(lua), .topcsb(topcsb), .ppn(ppn), .pil(pil),
    .trap(trap), .halted(halted), .test_out(test_out)
  );

  cpu_checker u_checker (
    .sysclk(sysclk), .check_en(check_en), .flush(flush), .test_id(test_id),
    .exp_mask(exp_mask), .exp_idb(exp_idb), .exp_cd(exp_cd), .exp_lua(exp_lua),
    .exp_csb(exp_csb), .exp_ppn(exp_ppn), .exp_pil(exp_pil), .exp_trap(exp_trap),
    .exp_halted(exp_halted), .exp_test(exp_test), .idb_out(idb_out),
    .cd_out(cd_out), .lua(lua), .topcsb(topcsb), .ppn(ppn), .pil(pil),
    .trap(trap), .halted(halted), .test_out(test_out),
    .mismatches(mismatches), .tests_run(tests_run), .tests_failed(tests_failed)
  );

  initial begin
    sysclk = 1'b0;
    forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
  end

  // Fills the record arrays, clears load_ok on any problem
  task automatic read_golden();
    int fd, lineno, fields;
    int t, run, rwcs, ldua, ldla, lcs, wpt, rpt, wsel, din, sn, sel, mask;
    int eio, ecd, elua, eppn, epil, etrap, ehalt, etest;
    logic [63:0] ecsb;
    string line;
    load_ok = 1'b1;
    nrec    = 0;
    lineno  = 0;
    fd = $fopen("bench/cpu_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden file bench/cpu_golden.txt");
      load_ok = 1'b0;
      return;
    end
    while (nrec < MAX_REC && $fgets(line, fd) != 0) begin
      lineno = lineno + 1;
      if (line.len() < 2 || line[0] == 8'h23) continue;  // Blank or comment
      fields = $sscanf(line,
        "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
        t, run, rwcs, ldua, ldla, lcs, wpt, rpt, wsel, din, sn, sel, mask,
        eio, ecd, elua, ecsb, eppn, epil, etrap, ehalt, etest);
      if (fields != 22) begin
        $display("Golden file line %0d is malformed, %0d fields read", lineno, fields);
        load_ok = 1'b0;
        break;
      end
      stim_mem[nrec].ctl.run      = run[0];
      stim_mem[nrec].ctl.rwcs     = rwcs[0];
      stim_mem[nrec].ctl.ldua     = ldua[0];
      stim_mem[nrec].ctl.ldla     = ldla[0];
      stim_mem[nrec].ctl.lcs      = lcs[0];
      stim_mem[nrec].ctl.wpt      = wpt[0];
      stim_mem[nrec].ctl.rpt      = rpt[0];
      stim_mem[nrec].ctl.word_sel = wsel[WSEL_W-1:0];
      stim_mem[nrec].idb_in       = din[DATA_W-1:0];
      stim_mem[nrec].stoc_n       = sn[0];
      stim_mem[nrec].sel          = sel[SEL_W-1:0];
      test_mem[nrec]  = t;
      mask_mem[nrec]  = mask[8:0];
      eidb_mem[nrec]  = eio[DATA_W-1:0];
      ecd_mem[nrec]   = ecd[DATA_W-1:0];
      elua_mem[nrec]  = elua[CS_AW-1:0];
      ecsb_mem[nrec]  = micro_t'(ecsb);
      eppn_mem[nrec]  = eppn[PPN_W-1:0];
      epil_mem[nrec]  = epil[PIL_W-1:0];
      etrap_mem[nrec] = etrap[0];
      ehalt_mem[nrec] = ehalt[0];
      etest_mem[nrec] = etest[TEST_W-1:0];
      nrec = nrec + 1;
    end
    $fclose(fd);
    if (load_ok && nrec == 0) begin
      $display("Golden file holds no test records");
      load_ok = 1'b0;
    end
  endtask

  // Watchdog, one clock per record plus margin
  initial begin
    wait (loaded);
    #(nrec * CLK_PERIOD + 2000);
    $display("Timeout, the run did not finish within %0d records", nrec);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    reset       = 1'b1;
    ctl         = '0;
    idb_in      = '0;
    stoc_n      = 1'b1;   // CD buffer off
    sel_testmux = '0;
    check_en    = 1'b0;
    flush       = 1'b0;
    test_id     = 0;
    exp_mask    = '0;
    {exp_idb, exp_cd, exp_lua, exp_csb, exp_ppn} = '0;
    {exp_pil, exp_trap, exp_halted, exp_test}    = '0;
    read_golden();
    if (!load_ok) begin
      $display("Testbench failed");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (3) @(posedge sysclk);
      reset <= 1'b0;
      for (int i = 0; i < nrec; i++) begin
        @(posedge sysclk);
        ctl         <= stim_mem[i].ctl;
        idb_in      <= stim_mem[i].idb_in;
        stoc_n      <= stim_mem[i].stoc_n;
        sel_testmux <= stim_mem[i].sel;
        test_id     <= test_mem[i];
        exp_mask    <= mask_mem[i];
        exp_idb     <= eidb_mem[i];
        exp_cd      <= ecd_mem[i];
        exp_lua     <= elua_mem[i];
        exp_csb     <= ecsb_mem[i];
        exp_ppn     <= eppn_mem[i];
        exp_pil     <= epil_mem[i];
        exp_trap    <= etrap_mem[i];
        exp_halted  <= ehalt_mem[i];
        exp_test    <= etest_mem[i];
        check_en    <= 1'b1;
      end
      @(posedge sysclk);
      check_en <= 1'b0;
      flush    <= 1'b1;   // Checker closes the last test
      ctl      <= '0;
      @(negedge sysclk);
      #1;
      $display("Tests run %0d, failed %0d, mismatches %0d",
               tests_run, tests_failed, mismatches);
      if (mismatches == 0 && tests_failed == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

endmodule

//--- bench/cpu_checker.sv
/* CPU board checker
   Samples the DUT ports mid-cycle, compares masked fields, counts per test */

`timescale 1ns/1ps

module cpu_checker import cpu_pkg::*; (
  input  logic       sysclk,
  input  logic       check_en,     // Current record is live
  input  logic       flush,        // Report the last open test
  input  int         test_id,
  input  logic [8:0] exp_mask,     // One bit per compared field
  input  data_word_t exp_idb,
  input  data_word_t exp_cd,
  input  cs_addr_t   exp_lua,
  input  micro_t     exp_csb,
  input  ppn_t       exp_ppn,
  input  pil_t       exp_pil,
  input  logic       exp_trap,
  input  logic       exp_halted,
  input  test_t      exp_test,
  input  data_word_t idb_out,
  input  data_word_t cd_out,
  input  cs_addr_t   lua,
  input  micro_t     topcsb,
  input  ppn_t       ppn,
  input  pil_t       pil,
  input  logic       trap,
  input  logic       halted,
  input  test_t      test_out,
  output int         mismatches,
  output int         tests_run,
  output int         tests_failed
);

  int cur_test  = 0;   // Zero until the first record
  int test_errs = 0;

  initial begin
    mismatches   = 0;
    tests_run    = 0;
    tests_failed = 0;
  end

  // Skipped when the mask bit is clear
  task automatic check_field(input string name, input int idx,
                             input logic [63:0] got, input logic [63:0] exp);
    if (exp_mask[idx] && (got !== exp)) begin
      $display("Fail at %0d ns: test %0d, %s is %h, expected %h",
               $time, cur_test, name, got, exp);
      test_errs  = test_errs + 1;
      mismatches = mismatches + 1;
    end
  endtask

  task automatic close_test();
    tests_run = tests_run + 1;
    if (test_errs != 0) tests_failed = tests_failed + 1;
    $display("Test %0d: %s, %0d mismatches", cur_test,
             (test_errs == 0) ? "pass" : "FAIL", test_errs);
    test_errs = 0;
  endtask

  // Negedge is half a cycle away from every input change
  always @(negedge sysclk) begin
    if (cur_test != 0 && (flush || (check_en && test_id != cur_test))) begin
      close_test();
      cur_test = 0;
    end
    if (check_en) begin
      cur_test = test_id;
      check_field("idb_out",  0, 64'(idb_out),  64'(exp_idb));
      check_field("cd_out",   1, 64'(cd_out),   64'(exp_cd));
      check_field("lua",      2, 64'(lua),      64'(exp_lua));
      check_field("topcsb",   3, 64'(topcsb),   64'(exp_csb));
      check_field("ppn",      4, 64'(ppn),      64'(exp_ppn));
      check_field("pil",      5, 64'(pil),      64'(exp_pil));
      check_field("trap",     6, 64'(trap),     64'(exp_trap));
      check_field("halted",   7, 64'(halted),   64'(exp_halted));
      check_field("test_out", 8, 64'(test_out), 64'(exp_test));
    end
  end

endmodule

//--- hw/cpu_board.sv
/* CPU board top level
   Sequencer, control store and MMU on a wired-OR IDB, with CD and PPN gates */

`timescale 1ns/1ps

module cpu_board import cpu_pkg::*; (
  input  logic             sysclk,
  input  logic             reset,
  input  board_ctrl_t      ctl,
  input  data_word_t       idb_in,
  input  logic             stoc_n,       // CD buffer enable, low active
  input  logic [SEL_W-1:0] sel_testmux,
  output data_word_t       idb_out,
  output data_word_t       cd_out,
  output cs_addr_t         lua,
  output micro_t           topcsb,
  output ppn_t             ppn,
  output pil_t             pil,
  output logic             trap,
  output logic             halted,
  output test_t            test_out
);

  data_word_t  bus_in;     // IDB as every block sees it
  data_word_t  proc_idb;
  data_word_t  cs_idb;
  data_word_t  mmu_idb;
  data_word_t  la;
  micro_t      cs_word;
  board_ctrl_t ctl_fwd;
  logic        lapa_en;
  logic        miss;
  ppn_t        ppn_raw;

  // Wired-OR IDB, idle drivers output zero
  assign idb_out = proc_idb | cs_idb | mmu_idb;
  assign bus_in  = idb_out | idb_in;

  assign cd_out  = stoc_n ? '0 : bus_in;    // Store-to-cache buffer
  assign ppn     = lapa_en ? ppn_raw : '0;  // Logical-to-physical gate
  assign topcsb  = cs_word;

  cpu_proc u_proc (
    .sysclk      (sysclk),
    .reset       (reset),
    .ctl         (ctl),
    .bus_in      (bus_in),
    .cs_word     (cs_word),
    .miss        (miss),
    .sel_testmux (sel_testmux),
    .lua         (lua),
    .la          (la),
    .ctl_fwd     (ctl_fwd),
    .proc_idb    (proc_idb),
    .lapa_en     (lapa_en),
    .pil         (pil),
    .trap        (trap),
    .halted      (halted),
    .test_out    (test_out)
  );

  cpu_cs u_cs (
    .sysclk   (sysclk),
    .lua      (lua),
    .lcs      (ctl_fwd.lcs),
    .rwcs     (ctl_fwd.rwcs),
    .word_sel (ctl_fwd.word_sel),
    .bus_in   (bus_in),
    .cs_word  (cs_word),
    .cs_idb   (cs_idb)
  );

  cpu_mmu u_mmu (
    .sysclk  (sysclk),
    .reset   (reset),
    .la      (la),
    .wpt     (ctl_fwd.wpt),
    .rpt     (ctl_fwd.rpt),
    .bus_in  (bus_in),
    .lapa_en (lapa_en),
    .mmu_idb (mmu_idb),
    .ppn_raw (ppn_raw),
    .miss    (miss)
  );

endmodule

//--- hw/cpu_mmu.sv
/* Memory management unit
   64-entry page table, write and readback via IDB, logical to physical page */

`timescale 1ns/1ps

module cpu_mmu import cpu_pkg::*; (
  input  logic       sysclk,
  input  logic       reset,
  input  data_word_t la,
  input  logic       wpt,      // Already gated to STOPPED
  input  logic       rpt,
  input  data_word_t bus_in,
  input  logic       lapa_en,
  output data_word_t mmu_idb,
  output ppn_t       ppn_raw,
  output logic       miss
);

  logic [PT_DEPTH-1:0] valid_q;       // Cleared on reset
  ppn_t                ppn_mem [PT_DEPTH];
  page_idx_t           page;
  pt_entry_t           wr_entry;
  pt_entry_t           rd_entry;

  // Logical page from the top of la
  assign page = la[DATA_W-1 -: PAGE_W];

  // IDB bit 15 is valid, bit 14 unused
  assign wr_entry = '{valid: bus_in[DATA_W-1], ppn: bus_in[PPN_W-1:0]};

  always_ff @(posedge sysclk) begin
    if (reset) begin
      valid_q <= '0;
    end else if (wpt) begin
      valid_q[page] <= wr_entry.valid;
    end
  end

  always_ff @(posedge sysclk) begin
    if (wpt) begin
      ppn_mem[page] <= wr_entry.ppn;
    end
  end

  // Invalid entries read as all zero
  always_comb begin
    rd_entry.valid = valid_q[page];
    rd_entry.ppn   = valid_q[page] ? ppn_mem[page] : '0;
  end

  // Readback in the same layout as the write
  assign mmu_idb = rpt ? {rd_entry.valid, {(DATA_W-PPN_W-1){1'b0}}, rd_entry.ppn} : '0;

  assign ppn_raw = rd_entry.ppn;
  assign miss    = lapa_en && !rd_entry.valid;  // Only while translating

endmodule

//--- hw/cpu_cs.sv
/* Writable control store, 256 x 64
   Loaded one 16-bit slice per strobe, slice readback onto the IDB */

`timescale 1ns/1ps

module cpu_cs import cpu_pkg::*; (
  input  logic              sysclk,
  input  cs_addr_t          lua,
  input  logic              lcs,       // Already gated to STOPPED
  input  logic              rwcs,
  input  logic [WSEL_W-1:0] word_sel,
  input  data_word_t        bus_in,
  output micro_t            cs_word,
  output data_word_t        cs_idb
);

  // Slice 0 sits in bits 15..0
  data_word_t [NUM_SLICES-1:0] mem [CS_DEPTH];

  data_word_t [NUM_SLICES-1:0] rd_word;  // Addressed word, as slices

  always_ff @(posedge sysclk) begin
    if (lcs) begin
      mem[lua][word_sel] <= bus_in;  // One slice per strobe
    end
  end

  // Asynchronous read, word follows lua in the same cycle
  assign rd_word = mem[lua];
  assign cs_word = micro_t'(rd_word);

  // Readback slice, zero otherwise for the wired-OR IDB
  assign cs_idb = rwcs ? rd_word[word_sel] : '0;

endmodule

//--- hw/cpu_proc.sv
/* Microsequencer
   Microaddress and logical address registers, run state, trap, PIL, test mux */

`timescale 1ns/1ps

module cpu_proc import cpu_pkg::*; (
  input  logic             sysclk,
  input  logic             reset,
  input  board_ctrl_t      ctl,
  input  data_word_t       bus_in,
  input  micro_t           cs_word,
  input  logic             miss,
  input  logic [SEL_W-1:0] sel_testmux,
  output cs_addr_t         lua,
  output data_word_t       la,
  output board_ctrl_t      ctl_fwd,   // Controls for CS and MMU
  output data_word_t       proc_idb,
  output logic             lapa_en,
  output pil_t             pil,
  output logic             trap,
  output logic             halted,
  output test_t            test_out
);

  seq_state_t state;
  seq_state_t state_nxt;
  cs_addr_t   lua_nxt;
  logic       stopped;
  logic       running;
  logic       retire;      // Current microword completes this edge

  assign stopped = (state == STOPPED);
  assign running = (state == RUNNING);
  assign retire  = running && ctl.run;  // Dropping run stops without retiring

  // Run state
  always_comb begin
    state_nxt = state;
    case (state)
      STOPPED: begin
        if (ctl.run) state_nxt = RUNNING;
      end
      RUNNING: begin
        if (!ctl.run) begin
          state_nxt = STOPPED;
        end else if (cs_word.halt) begin
          state_nxt = HALTED;      // Halt word parks here
        end
      end
      HALTED: begin
        if (!ctl.run) state_nxt = STOPPED;
      end
      default: state_nxt = STOPPED;
    endcase
  end

  // Next microaddress
  always_comb begin
    lua_nxt = lua;  // Hold by default, also on halt
    if (stopped && ctl.ldua) begin
      lua_nxt = bus_in[CS_AW-1:0];  // Manual load from IDB
    end else if (retire && !cs_word.halt) begin
      if (cs_word.branch_miss && miss) begin
        lua_nxt = cs_word.branch_addr;
      end else begin
        lua_nxt = cs_word.next_addr;
      end
    end
  end

  always_ff @(posedge sysclk) begin
    if (reset) begin
      state <= STOPPED;
      lua   <= '0;
      la    <= '0;
      pil   <= '0;
      trap  <= 1'b0;
    end else begin
      state <= state_nxt;
      lua   <= lua_nxt;
      if (stopped && ctl.ldla) begin
        la <= bus_in;                // Manual load
      end else if (retire && cs_word.ld_la) begin
        la <= cs_word.const_val;     // Microcode literal
      end
      if (retire) pil <= cs_word.pil;
      if (retire && miss) trap <= 1'b1;  // Sticky until reset
    end
  end

  // Panel strobes only act while stopped; read levels pass as is
  always_comb begin
    ctl_fwd      = ctl;
    ctl_fwd.ldua = ctl.ldua & stopped;
    ctl_fwd.ldla = ctl.ldla & stopped;
    ctl_fwd.lcs  = ctl.lcs & stopped;
    ctl_fwd.wpt  = ctl.wpt & stopped;
  end

  // IDB driver, zero when idle so the wired-OR works
  assign proc_idb = (running && cs_word.drive_la) ? la : '0;
  assign lapa_en  = running && cs_word.lapa;
  assign halted   = (state == HALTED);

  // Test multiplexer
  always_comb begin
    case (sel_testmux)
      3'd0:    test_out = lua[4:0];
      3'd1:    test_out = {3'b000, lua[7:6]};
      3'd2:    test_out = {trap, pil};
      3'd3:    test_out = la[DATA_W-1 -: TEST_W];  // la[15:11]
      default: test_out = '0;
    endcase
  end

endmodule

//--- hw/cpu_pkg.sv
/* CPU board shared definitions
   Widths, bus vectors, microword and control structs, sequencer states */

package cpu_pkg;

  // Bus and field widths
  localparam int DATA_W     = 16;  // IDB, CD, logical address
  localparam int CS_AW      = 8;   // Microaddress
  localparam int PAGE_W     = 6;   // Logical page number
  localparam int PPN_W      = 14;  // Physical page number
  localparam int PIL_W      = 4;   // Interrupt level
  localparam int TEST_W     = 5;   // Test mux output
  localparam int SEL_W      = 3;   // Test mux select
  localparam int WSEL_W     = 2;   // Microword slice select
  localparam int NUM_SLICES = 4;   // 16-bit slices per microword

  localparam int CS_DEPTH   = 256;  // Control store words
  localparam int PT_DEPTH   = 64;   // Page table entries

  typedef logic [DATA_W-1:0] data_word_t;
  typedef logic [CS_AW-1:0]  cs_addr_t;
  typedef logic [PAGE_W-1:0] page_idx_t;
  typedef logic [PPN_W-1:0]  ppn_t;
  typedef logic [PIL_W-1:0]  pil_t;
  typedef logic [TEST_W-1:0] test_t;

  // Microword, 64 bits, MSB first
  typedef struct packed {
    logic [22:0] spare;        // Unused bits
    data_word_t  const_val;    // Literal for la
    cs_addr_t    next_addr;    // Normal successor
    cs_addr_t    branch_addr;  // Taken on miss
    pil_t        pil;          // New interrupt level
    logic        ld_la;        // la <= const_val
    logic        drive_la;     // la onto IDB
    logic        lapa;         // Translate, drive PPN
    logic        branch_miss;  // Branch if MMU miss
    logic        halt;         // Stop sequencing
  } micro_t;

  // External board controls, strobes and levels
  typedef struct packed {
    logic              run;       // Level, sequencer enable
    logic              rwcs;      // Level, read control store slice
    logic              ldua;      // Pulse, load microaddress
    logic              ldla;      // Pulse, load logical address
    logic              lcs;       // Pulse, write control store slice
    logic              wpt;       // Pulse, write page table
    logic              rpt;       // Level, read page table
    logic [WSEL_W-1:0] word_sel;  // Microword slice
  } board_ctrl_t;

  // Page table entry
  typedef struct packed {
    logic valid;
    ppn_t ppn;
  } pt_entry_t;

  typedef enum logic [1:0] {
    STOPPED,
    RUNNING,
    HALTED
  } seq_state_t;

endpackage
